// File: common/mips_isa_pkg.sv
////////////////////////////////////////
// MIPS ISA definitions
// instruction fields, opcodes and funct codes
////////////////////////////////////////
`default_nettype none

package mips_isa_pkg;

	// instruction field widths
	localparam int OPCODE_W  = 6;
	localparam int FUNCT_W   = 6;
	localparam int REG_IDX_W = 5;
	localparam int SHAMT_W   = 5;
	localparam int IMM_W     = 16;

	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// v0 holds the program result
	localparam reg_idx_t REG_V0 = 5'd2;

	// primary opcodes, bits 31:26
	typedef enum logic [OPCODE_W-1:0] {
		OP_SPECIAL = 6'h00,
		OP_BEQ     = 6'h04,
		OP_ADDIU   = 6'h09,
		OP_ORI     = 6'h0d,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_LBU     = 6'h24,
		OP_SB      = 6'h28,
		OP_SW      = 6'h2b
	} opcode_t;

	// SPECIAL funct codes, bits 5:0
	typedef enum logic [FUNCT_W-1:0] {
		FN_SLL  = 6'h00,
		FN_JR   = 6'h08,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26
	} funct_t;

endpackage

`default_nettype wire

// File: common/cpu_core_pkg.sv
////////////////////////////////////////
// core datapath types
// widths, control struct, ALU ops, FSM states
////////////////////////////////////////
`default_nettype none

package cpu_core_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0]   word_t;
	typedef logic [XLEN/8-1:0] byte_en_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_LUI
	} alu_op_t;

	// bus sequencer states
	typedef enum logic [2:0] {
		S_RESET,
		S_FETCH,
		S_EXECUTE,
		S_MEMORY,
		S_WRITEBACK
	} seq_state_t;

	// decoded control for the held instruction
	typedef struct packed {
		alu_op_t alu_op;
		logic    use_imm;
		logic    zero_ext_imm;
		logic    reg_write;
		logic    dest_is_rd;
		logic    mem_read;
		logic    mem_write;
		logic    mem_byte;
		logic    branch_eq;
		logic    jump_reg;
	} instr_ctrl_t;

	// one data transfer on the bus
	typedef struct packed {
		word_t    address;
		byte_en_t byte_en;
		word_t    write_data;
	} data_access_t;

endpackage

`default_nettype wire

// File: rtl/control_unit.sv
////////////////////////////////////////
// control unit
// decodes the held instruction into control bits
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module control_unit
	import mips_isa_pkg::*;
	import cpu_core_pkg::*;
(
	input  word_t       instruction,
	output instr_ctrl_t ctrl,
	output reg_idx_t    rs,
	output reg_idx_t    rt,
	output reg_idx_t    rd
);

	opcode_t opcode;
	funct_t  funct;

	assign opcode = opcode_t'(instruction[31:26]);
	assign funct  = funct_t'(instruction[5:0]);
	assign rs     = instruction[25:21];
	assign rt     = instruction[20:16];

	// R-type writes rd, I-type writes rt
	assign rd = ctrl.dest_is_rd ? instruction[15:11] : instruction[20:16];

	always_comb begin
		// unknown encodings fall through as a nop
		ctrl = '0;
		ctrl.alu_op = ALU_ADD;
		case (opcode)
			OP_SPECIAL: begin
				ctrl.dest_is_rd = 1'b1;
				ctrl.reg_write  = 1'b1;
				case (funct)
					FN_ADDU: ctrl.alu_op = ALU_ADD;
					FN_SUBU: ctrl.alu_op = ALU_SUB;
					FN_AND:  ctrl.alu_op = ALU_AND;
					FN_OR:   ctrl.alu_op = ALU_OR;
					FN_XOR:  ctrl.alu_op = ALU_XOR;
					FN_SLL:  ctrl.alu_op = ALU_SLL;
					FN_JR: begin
						ctrl.reg_write = 1'b0;
						ctrl.jump_reg  = 1'b1;
					end
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			OP_ADDIU: begin
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			OP_ORI: begin
				ctrl.alu_op       = ALU_OR;
				ctrl.use_imm      = 1'b1;
				ctrl.zero_ext_imm = 1'b1;
				ctrl.reg_write    = 1'b1;
			end
			OP_LUI: begin
				ctrl.alu_op    = ALU_LUI;
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			OP_BEQ: begin
				ctrl.alu_op    = ALU_SUB;
				ctrl.branch_eq = 1'b1;
			end
			OP_LW, OP_LBU: begin
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.mem_read  = 1'b1;
				ctrl.mem_byte  = (opcode == OP_LBU);
			end
			OP_SW, OP_SB: begin
				ctrl.use_imm   = 1'b1;
				ctrl.mem_write = 1'b1;
				ctrl.mem_byte  = (opcode == OP_SB);
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/register_file.sv
////////////////////////////////////////
// register file
// 32 registers, r0 hard zero, v0 tap
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module register_file
	import mips_isa_pkg::*;
	import cpu_core_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  reg_idx_t read_address_1,
	input  reg_idx_t read_address_2,
	input  logic     write_enable,
	input  reg_idx_t write_address,
	input  word_t    write_data,
	output word_t    read_data_1,
	output word_t    read_data_2,
	output word_t    register_v0
);

	localparam int NUM_REGS = 2 ** REG_IDX_W;

	word_t regs [NUM_REGS];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (write_enable && write_address != '0) begin
			regs[write_address] <= write_data;
		end
	end

	assign read_data_1 = regs[read_address_1];
	assign read_data_2 = regs[read_address_2];
	assign register_v0 = regs[REG_V0];

	// r0 reads zero on both ports whatever was written
	assert property (@(posedge clk) disable iff (reset)
		(read_address_1 != '0 || read_data_1 == '0) &&
		(read_address_2 != '0 || read_data_2 == '0));

endmodule

`default_nettype wire

// File: rtl/execute_unit.sv
////////////////////////////////////////
// execute unit
// ALU, branch compare, next PC and address
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module execute_unit
	import mips_isa_pkg::*;
	import cpu_core_pkg::*;
(
	input  instr_ctrl_t ctrl,
	input  word_t       instruction,
	input  word_t       pc,
	input  word_t       operand_a,
	input  word_t       operand_b,
	output word_t       result,
	output word_t       effective_address,
	output word_t       next_pc
);

	logic [IMM_W-1:0]   imm;
	logic [SHAMT_W-1:0] shamt;
	word_t              ext_imm;
	word_t              alu_b;
	word_t              pc_plus_4;
	word_t              branch_target;

	assign imm   = instruction[IMM_W-1:0];
	assign shamt = instruction[10:6];

	// ORI zero extends, the rest sign extend
	assign ext_imm = ctrl.zero_ext_imm ? {{(XLEN-IMM_W){1'b0}}, imm}
	                                   : {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
	assign alu_b   = ctrl.use_imm ? ext_imm : operand_b;

	always_comb begin
		case (ctrl.alu_op)
			ALU_ADD: result = operand_a + alu_b;
			ALU_SUB: result = operand_a - alu_b;
			ALU_AND: result = operand_a & alu_b;
			ALU_OR:  result = operand_a | alu_b;
			ALU_XOR: result = operand_a ^ alu_b;
			ALU_SLL: result = operand_b << shamt;
			ALU_LUI: result = {imm, {(XLEN-IMM_W){1'b0}}};
			default: result = '0;
		endcase
	end

	// base plus offset for loads and stores
	assign effective_address = operand_a + ext_imm;

	assign pc_plus_4     = pc + word_t'(4);
	assign branch_target = pc_plus_4 + {ext_imm[XLEN-3:0], 2'b00};

	// no delay slot, a taken branch goes straight to its target
	always_comb begin
		if (ctrl.jump_reg) begin
			next_pc = operand_a;
		end else if (ctrl.branch_eq && operand_a == operand_b) begin
			next_pc = branch_target;
		end else begin
			next_pc = pc_plus_4;
		end
	end

endmodule

`default_nettype wire

// File: rtl/load_store_lane.sv
////////////////////////////////////////
// load/store lanes
// byte enables, store placement, load extract
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module load_store_lane
	import cpu_core_pkg::*;
(
	input  instr_ctrl_t  ctrl,
	input  word_t        effective_address,
	input  word_t        store_value,
	input  word_t        load_word,
	output data_access_t access,
	output word_t        load_value
);

	logic [1:0] lane;
	logic [7:0] load_byte;

	assign lane = effective_address[1:0];

	// bus addresses are always word aligned
	assign access.address = {effective_address[XLEN-1:2], 2'b00};

	always_comb begin
		if (!(ctrl.mem_read || ctrl.mem_write)) begin
			access.byte_en    = '0;
			access.write_data = store_value;
		end else if (ctrl.mem_byte) begin
			// one-hot lane, byte copied to every lane
			access.byte_en    = byte_en_t'(1) << lane;
			access.write_data = {(XLEN/8){store_value[7:0]}};
		end else begin
			access.byte_en    = '1;
			access.write_data = store_value;
		end
	end

	assign load_byte = load_word[8*lane +: 8];

	// LBU zero extends the selected lane
	assign load_value = ctrl.mem_byte ? {{(XLEN-8){1'b0}}, load_byte} : load_word;

endmodule

`default_nettype wire

// File: rtl/bus_sequencer.sv
////////////////////////////////////////
// bus sequencer
// Avalon master FSM, PC and instruction register
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module bus_sequencer
	import cpu_core_pkg::*;
#(
	parameter word_t RESET_VECTOR = 32'hbfc0_0000
) (
	input  logic         clk,
	input  logic         reset,
	input  instr_ctrl_t  ctrl,
	input  word_t        next_pc,
	input  data_access_t access,
	output word_t        pc,
	output word_t        instruction,
	output word_t        load_word,
	output logic         exec_commit,
	output logic         load_commit,
	output logic         active,
	output word_t        address,
	output logic         write,
	output logic         read,
	input  logic         waitrequest,
	output word_t        writedata,
	output byte_en_t     byteenable,
	input  word_t        readdata
);

	seq_state_t state;
	seq_state_t state_next;
	logic       halted;
	logic       fetch_req;
	logic       data_req;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state  <= S_RESET;
			pc     <= RESET_VECTOR;
			halted <= 1'b0;
		end else begin
			state <= state_next;
			// PC commits once per instruction, JR to 0 halts
			if (state == S_EXECUTE) begin
				pc <= next_pc;
				if (next_pc == '0) begin
					halted <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_req && !waitrequest) begin
			instruction <= readdata;
		end
		if (data_req && ctrl.mem_read && !waitrequest) begin
			load_word <= readdata;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			S_RESET:     state_next = S_FETCH;
			S_FETCH: begin
				if (!halted && !waitrequest) begin
					state_next = S_EXECUTE;
				end
			end
			S_EXECUTE: begin
				if (ctrl.mem_read || ctrl.mem_write) begin
					state_next = S_MEMORY;
				end else begin
					state_next = S_FETCH;
				end
			end
			S_MEMORY: begin
				if (!waitrequest) begin
					state_next = ctrl.mem_read ? S_WRITEBACK : S_FETCH;
				end
			end
			S_WRITEBACK: state_next = S_FETCH;
			default:     state_next = S_RESET;
		endcase
	end

	assign fetch_req = (state == S_FETCH) && !halted;
	assign data_req  = (state == S_MEMORY);

	assign read       = fetch_req || (data_req && ctrl.mem_read);
	assign write      = data_req && ctrl.mem_write;
	assign address    = data_req ? access.address : pc;
	assign writedata  = access.write_data;
	assign byteenable = fetch_req ? '1 : (data_req ? access.byte_en : '0);

	// loads write back later in their own cycle
	assign exec_commit = (state == S_EXECUTE) && !ctrl.mem_read;
	assign load_commit = (state == S_WRITEBACK);
	assign active      = !halted;

	assert property (@(posedge clk) disable iff (reset) !(read && write));

	assert property (@(posedge clk) disable iff (reset)
		(read || write) |-> (address[1:0] == 2'b00));

	// a stalled request holds until waitrequest drops
	assert property (@(posedge clk) disable iff (reset)
		(read || write) && waitrequest |=>
		$stable(read) && $stable(write) && $stable(address) &&
		$stable(byteenable) && $stable(writedata));

endmodule

`default_nettype wire

// File: rtl/mips_cpu_bus.sv
////////////////////////////////////////
// MIPS core with Avalon master port
// top level, connects the five units
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module mips_cpu_bus
	import mips_isa_pkg::*;
	import cpu_core_pkg::*;
#(
	parameter word_t RESET_VECTOR = 32'hbfc0_0000
) (
	input  logic     clk,
	input  logic     reset,
	output logic     active,
	output word_t    register_v0,
	output word_t    address,
	output logic     write,
	output logic     read,
	input  logic     waitrequest,
	output word_t    writedata,
	output byte_en_t byteenable,
	input  word_t    readdata
);

	instr_ctrl_t  ctrl;
	data_access_t access;
	reg_idx_t     rs;
	reg_idx_t     rt;
	reg_idx_t     rd;
	word_t        pc;
	word_t        instruction;
	word_t        next_pc;
	word_t        operand_a;
	word_t        operand_b;
	word_t        result;
	word_t        effective_address;
	word_t        load_word;
	word_t        load_value;
	word_t        reg_write_data;
	logic         reg_write_enable;
	logic         exec_commit;
	logic         load_commit;

	// writeback source and strobe
	assign reg_write_data   = ctrl.mem_read ? load_value : result;
	assign reg_write_enable = ctrl.reg_write && (exec_commit || load_commit);

	bus_sequencer #(
		.RESET_VECTOR(RESET_VECTOR)
	) i_bus_sequencer (
		.clk         (clk),
		.reset       (reset),
		.ctrl        (ctrl),
		.next_pc     (next_pc),
		.access      (access),
		.pc          (pc),
		.instruction (instruction),
		.load_word   (load_word),
		.exec_commit (exec_commit),
		.load_commit (load_commit),
		.active      (active),
		.address     (address),
		.write       (write),
		.read        (read),
		.waitrequest (waitrequest),
		.writedata   (writedata),
		.byteenable  (byteenable),
		.readdata    (readdata)
	);

	control_unit i_control_unit (
		.instruction (instruction),
		.ctrl        (ctrl),
		.rs          (rs),
		.rt          (rt),
		.rd          (rd)
	);

	register_file i_register_file (
		.clk            (clk),
		.reset          (reset),
		.read_address_1 (rs),
		.read_address_2 (rt),
		.write_enable   (reg_write_enable),
		.write_address  (rd),
		.write_data     (reg_write_data),
		.read_data_1    (operand_a),
		.read_data_2    (operand_b),
		.register_v0    (register_v0)
	);

	execute_unit i_execute_unit (
		.ctrl              (ctrl),
		.instruction       (instruction),
		.pc                (pc),
		.operand_a         (operand_a),
		.operand_b         (operand_b),
		.result            (result),
		.effective_address (effective_address),
		.next_pc           (next_pc)
	);

	load_store_lane i_load_store_lane (
		.ctrl              (ctrl),
		.effective_address (effective_address),
		.store_value       (operand_b),
		.load_word         (load_word),
		.access            (access),
		.load_value        (load_value)
	);

endmodule

`default_nettype wire

// File: verification/tb_memory_model.sv
////////////////////////////////////////
// Avalon slave memory for the testbench
// random waitrequest stalls, write log
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_memory_model
	import cpu_core_pkg::*;
#(
	parameter word_t CODE_BASE = 32'hbfc0_0000,
	parameter word_t DATA_BASE = 32'h0000_1000,
	parameter int    WORDS     = 64,
	parameter int    SEED      = 81687
) (
	input  logic     clk,
	input  word_t    address,
	input  logic     read,
	input  logic     write,
	input  word_t    writedata,
	input  byte_en_t byteenable,
	output logic     waitrequest,
	output word_t    readdata
);

	// lower half code, upper half data
	word_t       mem [2*WORDS];
	word_t       log_address [WORDS];
	byte_en_t    log_byte_en [WORDS];
	word_t       log_data [WORDS];
	int          log_count;
	logic [31:0] lfsr;
	int          stall_left;
	int          hit;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	// two LFSR bits give 0 to 3 wait cycles
	function automatic int next_stall();
		int n;
		n = 0;
		for (int b = 0; b < 2; b++) begin
			lfsr = lfsr_step(lfsr);
			n = 2 * n + int'(lfsr[0]);
		end
		return n;
	endfunction

	function automatic int slot(input word_t a);
		word_t code_off;
		word_t data_off;
		code_off = a - CODE_BASE;
		data_off = a - DATA_BASE;
		if (code_off < 4 * WORDS) begin
			return int'(code_off >> 2);
		end
		if (data_off < 4 * WORDS) begin
			return WORDS + int'(data_off >> 2);
		end
		return -1;
	endfunction

	function automatic word_t fill_pattern(input word_t a);
		return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
	endfunction

	initial begin
		for (int i = 0; i < WORDS; i++) begin
			mem[i]         = fill_pattern(CODE_BASE + 4 * i);
			mem[WORDS + i] = fill_pattern(DATA_BASE + 4 * i);
		end
		log_count   = 0;
		lfsr        = SEED;
		stall_left  = next_stall();
		waitrequest = (stall_left != 0);
		readdata    = '0;
		forever begin
			@(posedge clk);
			hit = slot(address);
			if ((read || write) && waitrequest) begin
				stall_left = stall_left - 1;
			end else if (read || write) begin
				// transfer ends this cycle
				if (write && hit >= 0) begin
					for (int b = 0; b < 4; b++) begin
						if (byteenable[b]) begin
							mem[hit][8*b +: 8] = writedata[8*b +: 8];
						end
					end
				end
				if (write && log_count < WORDS) begin
					log_address[log_count] = address;
					log_byte_en[log_count] = byteenable;
					log_data[log_count]    = writedata;
					log_count++;
				end
				stall_left = next_stall();
			end
			#1;
			waitrequest = (stall_left != 0);
			hit = slot(address);
			readdata = (hit >= 0) ? mem[hit] : '0;
		end
	end

endmodule

`default_nettype wire

// File: verification/tb_mips_cpu_bus.sv
////////////////////////////////////////
// testbench for the MIPS bus core
// runs a program against an ISA model
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_mips_cpu_bus
	import cpu_core_pkg::*;
();

	localparam word_t RESET_VECTOR = 32'hbfc0_0000;
	localparam word_t DATA_BASE    = 32'h0000_1000;
	localparam int    WORDS        = 64;
	localparam int    MAX_STEPS    = 1000;

	// MIPS32 encodings
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_LUI     = 6'h0f;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_LBU     = 6'h24;
	localparam logic [5:0] OP_SB      = 6'h28;
	localparam logic [5:0] OP_SW      = 6'h2b;
	localparam logic [5:0] FN_SLL     = 6'h00;
	localparam logic [5:0] FN_JR      = 6'h08;
	localparam logic [5:0] FN_ADDU    = 6'h21;
	localparam logic [5:0] FN_SUBU    = 6'h23;
	localparam logic [5:0] FN_AND     = 6'h24;
	localparam logic [5:0] FN_OR      = 6'h25;
	localparam logic [5:0] FN_XOR     = 6'h26;

	logic     clk = 1'b0;
	logic     reset;
	logic     active;
	word_t    register_v0;
	word_t    address;
	logic     write;
	logic     read;
	logic     waitrequest;
	word_t    writedata;
	byte_en_t byteenable;
	word_t    readdata;

	word_t    ref_mem [2*WORDS];
	word_t    ref_log_address [WORDS];
	byte_en_t ref_log_byte_en [WORDS];
	word_t    ref_log_data [WORDS];
	int       ref_log_count;
	int       ref_steps;
	word_t    ref_v0;
	int       cycle_limit = MAX_STEPS * 12;
	int       cycles = 0;
	logic     first_read_seen = 1'b0;
	logic     fetch_done = 1'b0;
	logic     halt_seen;

	always #5 clk = ~clk;

	function automatic word_t encode_r(input logic [5:0] funct, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt);
		return {OP_SPECIAL, rs, rt, rd, shamt, funct};
	endfunction

	function automatic word_t encode_i(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic int mem_slot(input word_t a);
		word_t code_off;
		word_t data_off;
		code_off = a - RESET_VECTOR;
		data_off = a - DATA_BASE;
		if (code_off < 4 * WORDS) begin
			return int'(code_off >> 2);
		end
		if (data_off < 4 * WORDS) begin
			return WORDS + int'(data_off >> 2);
		end
		return -1;
	endfunction

	function automatic word_t lane_mask(input byte_en_t be);
		return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
	endfunction

	// instruction level model, no delay slot, JR to 0 halts
	function automatic word_t run_reference();
		word_t      regs [32];
		word_t      pc;
		word_t      ir;
		word_t      sext;
		word_t      ea;
		word_t      dword;
		word_t      wd;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [1:0] lane;
		byte_en_t   be;
		int         s;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		pc = RESET_VECTOR;
		ref_steps = 0;
		ref_log_count = 0;
		while (pc != '0 && ref_steps < MAX_STEPS) begin
			s = mem_slot(pc);
			if (s < 0) begin
				ref_steps = MAX_STEPS;
				break;
			end
			ir = ref_mem[s];
			ref_steps++;
			rs = ir[25:21];
			rt = ir[20:16];
			rd = ir[15:11];
			sext = {{16{ir[15]}}, ir[15:0]};
			ea = regs[rs] + sext;
			lane = ea[1:0];
			s = mem_slot({ea[31:2], 2'b00});
			dword = (s >= 0) ? ref_mem[s] : '0;
			pc = pc + 32'd4;
			case (ir[31:26])
				OP_SPECIAL: begin
					case (ir[5:0])
						FN_ADDU: regs[rd] = regs[rs] + regs[rt];
						FN_SUBU: regs[rd] = regs[rs] - regs[rt];
						FN_AND:  regs[rd] = regs[rs] & regs[rt];
						FN_OR:   regs[rd] = regs[rs] | regs[rt];
						FN_XOR:  regs[rd] = regs[rs] ^ regs[rt];
						FN_SLL:  regs[rd] = regs[rt] << ir[10:6];
						FN_JR:   pc = regs[rs];
						default: ;
					endcase
				end
				OP_ADDIU: regs[rt] = regs[rs] + sext;
				OP_ORI:   regs[rt] = regs[rs] | {16'h0, ir[15:0]};
				OP_LUI:   regs[rt] = {ir[15:0], 16'h0};
				OP_BEQ: begin
					if (regs[rs] == regs[rt]) begin
						pc = pc + {sext[29:0], 2'b00};
					end
				end
				OP_LW:  regs[rt] = dword;
				OP_LBU: regs[rt] = {24'h0, dword[8*lane +: 8]};
				OP_SW, OP_SB: begin
					be = (ir[31:26] == OP_SB) ? 4'b0001 << lane : 4'b1111;
					wd = (ir[31:26] == OP_SB) ? {4{regs[rt][7:0]}} : regs[rt];
					dword = (dword & ~lane_mask(be)) | (wd & lane_mask(be));
					if (s >= 0) begin
						ref_mem[s] = dword;
					end
					ref_log_address[ref_log_count] = {ea[31:2], 2'b00};
					ref_log_byte_en[ref_log_count] = be;
					ref_log_data[ref_log_count]    = wd;
					ref_log_count++;
				end
				default: ;
			endcase
			regs[0] = '0;
		end
		return regs[2];
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display(">>> FAIL");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_value(input string name, input word_t got, input word_t expected);
		if (got !== expected) begin
			$display("error: %s is %h, expected %h", name, got, expected);
			abort_run($sformatf("%s mismatch", name));
		end
	endtask

	task automatic load_program();
		// t0 = data base, ALU and immediate ops
		i_mem.mem[0]  = encode_i(OP_ORI, 5'd0, 5'd8, 16'h1000);
		i_mem.mem[1]  = encode_i(OP_ADDIU, 5'd0, 5'd9, 16'h1234);
		i_mem.mem[2]  = encode_i(OP_LUI, 5'd0, 5'd10, 16'hdead);
		i_mem.mem[3]  = encode_i(OP_ORI, 5'd10, 5'd10, 16'hbeef);
		i_mem.mem[4]  = encode_r(FN_ADDU, 5'd9, 5'd10, 5'd11, 5'd0);
		i_mem.mem[5]  = encode_r(FN_SUBU, 5'd10, 5'd9, 5'd12, 5'd0);
		i_mem.mem[6]  = encode_r(FN_AND, 5'd11, 5'd12, 5'd13, 5'd0);
		i_mem.mem[7]  = encode_r(FN_OR, 5'd13, 5'd9, 5'd14, 5'd0);
		i_mem.mem[8]  = encode_r(FN_XOR, 5'd14, 5'd10, 5'd15, 5'd0);
		i_mem.mem[9]  = encode_r(FN_SLL, 5'd0, 5'd15, 5'd16, 5'd5);
		i_mem.mem[10] = encode_i(OP_ADDIU, 5'd16, 5'd17, 16'hfffd);
		// stores, then loads incl. a byte with bit 7 set
		i_mem.mem[11] = encode_i(OP_SW, 5'd8, 5'd10, 16'h0000);
		i_mem.mem[12] = encode_i(OP_SB, 5'd8, 5'd9, 16'h0009);
		i_mem.mem[13] = encode_i(OP_LBU, 5'd8, 5'd19, 16'h0003);
		i_mem.mem[14] = encode_i(OP_LW, 5'd8, 5'd21, 16'h0010);
		// not taken, then taken over a poison ADDIU
		i_mem.mem[15] = encode_i(OP_BEQ, 5'd9, 5'd10, 16'h0001);
		i_mem.mem[16] = encode_r(FN_ADDU, 5'd17, 5'd19, 5'd2, 5'd0);
		i_mem.mem[17] = encode_i(OP_BEQ, 5'd8, 5'd8, 16'h0001);
		i_mem.mem[18] = encode_i(OP_ADDIU, 5'd0, 5'd2, 16'h7bad);
		i_mem.mem[19] = encode_r(FN_XOR, 5'd2, 5'd21, 5'd2, 5'd0);
		i_mem.mem[20] = encode_i(OP_LBU, 5'd8, 5'd20, 16'h0009);
		i_mem.mem[21] = encode_r(FN_ADDU, 5'd2, 5'd20, 5'd2, 5'd0);
		i_mem.mem[22] = encode_i(OP_SW, 5'd8, 5'd2, 16'h0004);
		i_mem.mem[23] = encode_r(FN_JR, 5'd0, 5'd0, 5'd0, 5'd0);
	endtask

	mips_cpu_bus #(
		.RESET_VECTOR(RESET_VECTOR)
	) i_dut (
		.clk         (clk),
		.reset       (reset),
		.active      (active),
		.register_v0 (register_v0),
		.address     (address),
		.write       (write),
		.read        (read),
		.waitrequest (waitrequest),
		.writedata   (writedata),
		.byteenable  (byteenable),
		.readdata    (readdata)
	);

	tb_memory_model #(
		.CODE_BASE (RESET_VECTOR),
		.DATA_BASE (DATA_BASE),
		.WORDS     (WORDS),
		.SEED      (81687)
	) i_mem (
		.clk         (clk),
		.address     (address),
		.read        (read),
		.write       (write),
		.writedata   (writedata),
		.byteenable  (byteenable),
		.waitrequest (waitrequest),
		.readdata    (readdata)
	);

	// bus protocol monitor and cycle limit
	always @(posedge clk) begin
		if (!reset) begin
			cycles++;
			if (cycles > cycle_limit) begin
				abort_run("timeout: the core did not halt within the cycle limit");
			end
			if ((read || write) && mem_slot(address) < 0) begin
				abort_run("bus access outside the mapped memory");
			end
			if (halt_seen && (read || write)) begin
				abort_run("bus access after the core halted");
			end
			if (write && !fetch_done) begin
				abort_run("write before the first fetch completed");
			end
			if (read && !first_read_seen) begin
				first_read_seen = 1'b1;
				check_value("address", address, RESET_VECTOR);
			end
			if (read && !waitrequest) begin
				fetch_done = 1'b1;
			end
		end
	end

	initial begin
		word_t mask;
		reset = 1'b1;
		halt_seen = 1'b0;
		#1;
		load_program();
		for (int i = 0; i < 2 * WORDS; i++) begin
			ref_mem[i] = i_mem.mem[i];
		end
		ref_v0 = run_reference();
		if (ref_steps >= MAX_STEPS) begin
			abort_run("reference model never reached the halting JR");
		end
		cycle_limit = ref_steps * 12 + 50;
		repeat (10) @(posedge clk);
		check_value("active", word_t'(active), 32'd1);
		check_value("read", word_t'(read), 32'd0);
		check_value("write", word_t'(write), 32'd0);
		check_value("byteenable", word_t'(byteenable), 32'd0);
		#1;
		reset = 1'b0;
		wait (active == 1'b0);
		halt_seen = 1'b1;
		repeat (20) @(posedge clk);
		check_value("register_v0", register_v0, ref_v0);
		check_value("write count", word_t'(i_mem.log_count), word_t'(ref_log_count));
		for (int i = 0; i < ref_log_count; i++) begin
			mask = lane_mask(ref_log_byte_en[i]);
			check_value($sformatf("write %0d address", i), i_mem.log_address[i],
				ref_log_address[i]);
			check_value($sformatf("write %0d byteenable", i), word_t'(i_mem.log_byte_en[i]),
				word_t'(ref_log_byte_en[i]));
			check_value($sformatf("write %0d writedata", i), i_mem.log_data[i] & mask,
				ref_log_data[i] & mask);
		end
		for (int i = 0; i < 2 * WORDS; i++) begin
			check_value($sformatf("memory word %0d", i), i_mem.mem[i], ref_mem[i]);
		end
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
common/mips_isa_pkg.sv
common/cpu_core_pkg.sv
rtl/control_unit.sv
rtl/register_file.sv
rtl/execute_unit.sv
rtl/load_store_lane.sv
rtl/bus_sequencer.sv
rtl/mips_cpu_bus.sv
verification/tb_memory_model.sv
verification/tb_mips_cpu_bus.sv

// File: run_sim.sh
#!/bin/sh
# build and run the MIPS bus core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_mips_cpu_bus -f all.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q '^>>> PASS$'; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
